// ==== hdl/hex_loader_params.svh ====
`ifndef HEX_LOADER_PARAMS_SVH
`define HEX_LOADER_PARAMS_SVH

// --------------------
// uart timing
// --------------------

// clock cycles per uart bit, short so simulation stays fast
`define HEX_LOADER_CLKS_PER_BIT 16

// --------------------
// line parsing
// --------------------

// idle cycles allowed inside a line before it is abandoned
`define HEX_LOADER_TIMEOUT_CYCLES 2000

// most hex digits accepted in one field
`define HEX_LOADER_MAX_DIGITS 8

`endif

// ==== hdl/hex_loader_pkg.sv ====
package hex_loader_pkg;

    // axi response code for a good write
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // one parsed hex field as seen by the assembler
    typedef struct packed {
        logic [31:0] value;
        logic [3:0]  digits;
        logic        overflow;
    } hex_field_t;

    // address and data of one write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } hex_record_t;

    // --------------------
    // axi4-lite write channels
    // --------------------

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
    } axil_aw_t;

    typedef struct packed {
        logic        wvalid;
        logic [31:0] wdata;
    } axil_w_t;

    typedef struct packed {
        logic       bvalid;
        logic [1:0] bresp;
    } axil_b_t;

    typedef struct packed {
        logic        busy;
        logic        error;
        logic [15:0] records_written;
        logic [7:0]  error_count;
    } loader_status_t;

endpackage

// ==== hdl/uart_receiver.sv ====
`timescale 1ns/1ps
`include "hex_loader_params.svh"

module uart_receiver
#(
    parameter int clks_per_bit = `HEX_LOADER_CLKS_PER_BIT
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] half_bit = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;

    assign rx_s = rx_sync[1];

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rx_sync <= 2'b11;
        else
            rx_sync <= {rx_sync[0], rx};
    end

    // --------------------
    // frame state machine
    // --------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    cnt <= '0;
                    if (!rx_s)
                        state <= START;
                end
                START:
                begin
                    // start bit must still be low at mid-bit
                    if (cnt == half_bit)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? IDLE : DATA;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                DATA:
                begin
                    if (cnt == full_bit)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= STOP;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                begin
                    // no pulse on a framing error
                    if (cnt == full_bit)
                    begin
                        state      <= IDLE;
                        byte_valid <= rx_s;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk)
    begin
        if (state == DATA && cnt == full_bit)
            byte_data <= {rx_s, byte_data[7:1]};
    end

endmodule

// ==== hdl/hex_field_accumulator.sv ====
`timescale 1ns/1ps
`include "hex_loader_params.svh"

module hex_field_accumulator
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       digit_valid,
    input  logic [3:0]                 nibble,
    input  logic                       clear,
    output hex_loader_pkg::hex_field_t field
);

    localparam logic [3:0] max_digits = 4'(`HEX_LOADER_MAX_DIGITS);

    logic full;

    assign full = (field.digits == max_digits);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            field <= '0;
        else if (clear)
            field <= '0;
        else if (digit_valid)
        begin
            // extra digits only mark the field bad, value is kept
            if (full)
                field.overflow <= 1'b1;
            else
            begin
                field.value  <= {field.value[27:0], nibble};
                field.digits <= field.digits + 4'd1;
            end
        end
    end

endmodule

// ==== hdl/record_assembler.sv ====
`timescale 1ns/1ps
`include "hex_loader_params.svh"

module record_assembler
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        byte_valid,
    input  logic [7:0]                  byte_data,
    output logic                        addr_digit_valid,
    output logic                        data_digit_valid,
    output logic [3:0]                  nibble,
    output logic                        addr_clear,
    output logic                        data_clear,
    input  hex_loader_pkg::hex_field_t  addr_field,
    input  hex_loader_pkg::hex_field_t  data_field,
    output logic                        rec_valid,
    output hex_loader_pkg::hex_record_t rec,
    input  logic                        rec_ready,
    output logic                        line_active,
    output logic                        error
);

    localparam int to_w = $clog2(`HEX_LOADER_TIMEOUT_CYCLES + 1);
    localparam logic [to_w-1:0] to_last = to_w'(`HEX_LOADER_TIMEOUT_CYCLES - 1);

    typedef enum logic [1:0] {ADDR, GAP, DATA, DISCARD} state_t;
    typedef enum logic [2:0] {CH_HEX, CH_SPACE, CH_CR, CH_LF, CH_OTHER} char_t;

    state_t          state;
    state_t          state_next;
    char_t           cls;
    logic            line_nonempty;
    logic [to_w-1:0] to_cnt;
    logic            to_running;
    logic            timeout_hit;
    logic            clear_fields;
    logic            load_rec;
    logic            err_evt;
    logic            line_bad;

    // --------------------
    // character decode
    // --------------------

    always_comb
    begin
        nibble = 4'h0;
        cls    = CH_OTHER;
        if (byte_data >= "0" && byte_data <= "9")
        begin
            cls    = CH_HEX;
            nibble = 4'(byte_data - "0");
        end
        else if (byte_data >= "A" && byte_data <= "F")
        begin
            cls    = CH_HEX;
            nibble = 4'(byte_data - "A" + 8'd10);
        end
        else if (byte_data >= "a" && byte_data <= "f")
        begin
            cls    = CH_HEX;
            nibble = 4'(byte_data - "a" + 8'd10);
        end
        else if (byte_data == " ")
            cls = CH_SPACE;
        else if (byte_data == 8'h0d)
            cls = CH_CR;
        else if (byte_data == 8'h0a)
            cls = CH_LF;
    end

    assign line_bad = (addr_field.digits == 4'd0) || addr_field.overflow
                      || data_field.overflow;

    // a byte arriving on the expiry cycle wins over the timeout
    assign to_running  = line_nonempty && (state != DISCARD);
    assign timeout_hit = to_running && !byte_valid && (to_cnt == to_last);

    // --------------------
    // line state machine
    // --------------------

    always_comb
    begin
        state_next       = state;
        addr_digit_valid = 1'b0;
        data_digit_valid = 1'b0;
        clear_fields     = 1'b0;
        load_rec         = 1'b0;
        err_evt          = 1'b0;
        if (timeout_hit)
        begin
            err_evt    = 1'b1;
            state_next = DISCARD;
        end
        else if (byte_valid && cls != CH_CR)
        begin
            if (cls == CH_LF)
            begin
                clear_fields = 1'b1;
                state_next   = ADDR;
                case (state)
                    // blank line is dropped silently
                    ADDR:    err_evt = line_nonempty;
                    GAP:     err_evt = 1'b1;
                    DATA:
                    begin
                        // overrun when the buffer is still held
                        err_evt  = line_bad || (rec_valid && !rec_ready);
                        load_rec = !err_evt;
                    end
                    default: err_evt = 1'b0;
                endcase
            end
            else if (state == ADDR && cls == CH_HEX)
                addr_digit_valid = 1'b1;
            else if (state == ADDR && cls == CH_SPACE)
                state_next = GAP;
            else if (state == GAP && cls == CH_SPACE)
                state_next = GAP;
            else if ((state == GAP || state == DATA) && cls == CH_HEX)
            begin
                data_digit_valid = 1'b1;
                state_next       = DATA;
            end
            else if (state != DISCARD)
            begin
                err_evt    = 1'b1;
                state_next = DISCARD;
            end
        end
    end

    assign addr_clear  = clear_fields;
    assign data_clear  = clear_fields;
    assign line_active = line_nonempty;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state         <= ADDR;
            line_nonempty <= 1'b0;
            to_cnt        <= '0;
            rec_valid     <= 1'b0;
            error         <= 1'b0;
        end
        else
        begin
            state <= state_next;
            error <= err_evt;
            if (byte_valid && cls == CH_LF)
                line_nonempty <= 1'b0;
            else if (byte_valid && cls != CH_CR)
                line_nonempty <= 1'b1;
            if (byte_valid || !to_running)
                to_cnt <= '0;
            else
                to_cnt <= to_cnt + 1'b1;
            if (load_rec)
                rec_valid <= 1'b1;
            else if (rec_ready)
                rec_valid <= 1'b0;
        end
    end

    // one-record buffer
    always_ff @(posedge clk)
    begin
        if (load_rec)
        begin
            rec.addr <= addr_field.value;
            rec.data <= data_field.value;
        end
    end

endmodule

// ==== hdl/axil_write_master.sv ====
`timescale 1ns/1ps

module axil_write_master
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rec_valid,
    input  hex_loader_pkg::hex_record_t rec,
    output logic                        rec_ready,
    output hex_loader_pkg::axil_aw_t    aw,
    input  logic                        awready,
    output hex_loader_pkg::axil_w_t     w,
    input  logic                        wready,
    input  hex_loader_pkg::axil_b_t     b,
    output logic                        bready,
    output logic                        write_done,
    output logic                        write_error
);

    import hex_loader_pkg::*;

    typedef enum logic [1:0] {IDLE, ADDR_DATA, RESP} state_t;

    state_t      state;
    logic        awvalid_q;
    logic        wvalid_q;
    logic [31:0] awaddr_q;
    logic [31:0] wdata_q;
    logic        aw_done;
    logic        w_done;
    logic        aw_fire;
    logic        w_fire;

    assign aw = '{awvalid: awvalid_q, awaddr: awaddr_q};
    assign w  = '{wvalid: wvalid_q, wdata: wdata_q};

    assign aw_fire   = awvalid_q && awready;
    assign w_fire    = wvalid_q && wready;
    assign rec_ready = (state == IDLE);
    assign bready    = (state == RESP);

    // --------------------
    // write sequencing
    // --------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state       <= IDLE;
            awvalid_q   <= 1'b0;
            wvalid_q    <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            write_done  <= 1'b0;
            write_error <= 1'b0;
        end
        else
        begin
            write_done  <= 1'b0;
            write_error <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (rec_valid)
                    begin
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                        state     <= ADDR_DATA;
                    end
                end
                ADDR_DATA:
                begin
                    // aw and w finish in any order
                    if (aw_fire)
                    begin
                        awvalid_q <= 1'b0;
                        aw_done   <= 1'b1;
                    end
                    if (w_fire)
                    begin
                        wvalid_q <= 1'b0;
                        w_done   <= 1'b1;
                    end
                    if ((aw_done || aw_fire) && (w_done || w_fire))
                    begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= RESP;
                    end
                end
                RESP:
                begin
                    if (b.bvalid)
                    begin
                        write_done  <= 1'b1;
                        write_error <= (b.bresp != axi_resp_okay);
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rec_valid && rec_ready)
        begin
            awaddr_q <= rec.addr;
            wdata_q  <= rec.data;
        end
    end

endmodule

// ==== hdl/hex_loader_top.sv ====
`timescale 1ns/1ps
`include "hex_loader_params.svh"

module hex_loader_top
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           uart_rx,
    output hex_loader_pkg::axil_aw_t       aw,
    input  logic                           awready,
    output hex_loader_pkg::axil_w_t        w,
    input  logic                           wready,
    input  hex_loader_pkg::axil_b_t        b,
    output logic                           bready,
    output hex_loader_pkg::loader_status_t status
);

    import hex_loader_pkg::*;

    logic        byte_valid;
    logic [7:0]  byte_data;
    logic        addr_digit_valid;
    logic        data_digit_valid;
    logic [3:0]  nibble;
    logic        addr_clear;
    logic        data_clear;
    hex_field_t  addr_field;
    hex_field_t  data_field;
    hex_record_t rec;
    logic        rec_valid;
    logic        rec_ready;
    logic        line_active;
    logic        asm_error;
    logic        write_done;
    logic        write_error;
    logic [15:0] records_written;
    logic [7:0]  error_count;
    logic [8:0]  error_sum;

    uart_receiver #(.clks_per_bit(`HEX_LOADER_CLKS_PER_BIT)) i_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (uart_rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    // address and data fields fill side by side
    hex_field_accumulator i_addr_field (
        .clk         (clk),
        .rst         (rst),
        .digit_valid (addr_digit_valid),
        .nibble      (nibble),
        .clear       (addr_clear),
        .field       (addr_field)
    );

    hex_field_accumulator i_data_field (
        .clk         (clk),
        .rst         (rst),
        .digit_valid (data_digit_valid),
        .nibble      (nibble),
        .clear       (data_clear),
        .field       (data_field)
    );

    record_assembler i_assembler (
        .clk              (clk),
        .rst              (rst),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data),
        .addr_digit_valid (addr_digit_valid),
        .data_digit_valid (data_digit_valid),
        .nibble           (nibble),
        .addr_clear       (addr_clear),
        .data_clear       (data_clear),
        .addr_field       (addr_field),
        .data_field       (data_field),
        .rec_valid        (rec_valid),
        .rec              (rec),
        .rec_ready        (rec_ready),
        .line_active      (line_active),
        .error            (asm_error)
    );

    axil_write_master i_write_master (
        .clk         (clk),
        .rst         (rst),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .rec_ready   (rec_ready),
        .aw          (aw),
        .awready     (awready),
        .w           (w),
        .wready      (wready),
        .b           (b),
        .bready      (bready),
        .write_done  (write_done),
        .write_error (write_error)
    );

    // --------------------
    // status counters
    // --------------------

    // both error sources may fire in one cycle
    assign error_sum = {1'b0, error_count} + 9'(asm_error) + 9'(write_error);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            records_written <= '0;
            error_count     <= '0;
        end
        else
        begin
            if (write_done && !write_error)
                records_written <= records_written + 16'd1;
            error_count <= error_sum[8] ? 8'hff : error_sum[7:0];
        end
    end

    // write master is busy whenever it is not ready for a record
    assign status = '{busy:            line_active || rec_valid || !rec_ready,
                      error:           asm_error || write_error,
                      records_written: records_written,
                      error_count:     error_count};

endmodule

// ==== sim/hex_loader_properties.sv ====
`timescale 1ns/1ps

module hex_loader_properties
(
    input logic                           clk,
    input logic                           rst,
    input hex_loader_pkg::axil_aw_t       aw,
    input logic                           awready,
    input hex_loader_pkg::axil_w_t        w,
    input logic                           wready,
    input logic                           bready,
    input hex_loader_pkg::loader_status_t status
);

    int unsigned violations = 0;

    // address held until accepted
    aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw.awvalid && !awready |=> aw.awvalid && $stable(aw.awaddr))
    else
    begin
        $error("awvalid dropped or awaddr changed before awready");
        violations++;
    end

    // write data held until accepted
    w_stable: assert property (@(posedge clk) disable iff (rst)
        w.wvalid && !wready |=> w.wvalid && $stable(w.wdata))
    else
    begin
        $error("wvalid dropped or wdata changed before wready");
        violations++;
    end

    // response only after the address phase
    b_after_aw: assert property (@(posedge clk) disable iff (rst)
        !(bready && aw.awvalid))
    else
    begin
        $error("bready high while awvalid is still pending");
        violations++;
    end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !aw.awvalid && !w.wvalid && !bready && !status.error)
    else
    begin
        $error("control output high during reset");
        violations++;
    end

endmodule

bind hex_loader_top hex_loader_properties i_props (
    .clk     (clk),
    .rst     (rst),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .bready  (bready),
    .status  (status)
);

// ==== sim/tb_hex_loader.sv ====
`timescale 1ns/1ps
`include "hex_loader_params.svh"

module tb_hex_loader;

    import hex_loader_pkg::*;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam int quiet_cycles = 4;
    localparam int quiet_limit  = 20000;

    logic           clk = 1'b0;
    logic           rst;
    logic           uart_rx;
    axil_aw_t       aw;
    logic           awready = 1'b0;
    axil_w_t        w;
    logic           wready = 1'b0;
    axil_b_t        b = '0;
    logic           bready;
    loader_status_t status;

    // slave model state
    logic        stall = 1'b0;
    logic        slow = 1'b0;
    logic [1:0]  resp_next = 2'b00;
    logic        aw_got;
    logic        w_got;
    logic [31:0] got_addr;
    logic [31:0] got_data;
    int          aw_wait;
    int          w_wait;
    int          b_wait;
    logic [31:0] wr_addr_q[$];
    logic [31:0] wr_data_q[$];

    // stimulus table, one entry per line of text
    string       tbl_text[$];
    logic        tbl_write[$];
    logic [31:0] tbl_addr[$];
    logic [31:0] tbl_data[$];
    logic [1:0]  tbl_resp[$];

    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int next_wr = 0;
    int exp_written = 0;
    int exp_errors = 0;
    int error_pulses = 0;

    always #4 clk = ~clk;

    hex_loader_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .uart_rx (uart_rx),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .status  (status)
    );

    // --------------------
    // axi4-lite slave model
    // --------------------

    function automatic int pick_delay();
        if (slow)
            return int'($urandom_range(5, 0));
        return 0;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            b       <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_wait <= 0;
            w_wait  <= 0;
            b_wait  <= 0;
        end
        else
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (aw.awvalid && awready)
            begin
                aw_got   <= 1'b1;
                got_addr <= aw.awaddr;
                aw_wait  <= pick_delay();
            end
            else if (aw.awvalid && !aw_got && !stall)
            begin
                if (aw_wait == 0)
                    awready <= 1'b1;
                else
                    aw_wait <= aw_wait - 1;
            end
            if (w.wvalid && wready)
            begin
                w_got    <= 1'b1;
                got_data <= w.wdata;
                w_wait   <= pick_delay();
            end
            else if (w.wvalid && !w_got && !stall)
            begin
                if (w_wait == 0)
                    wready <= 1'b1;
                else
                    w_wait <= w_wait - 1;
            end
            // response once both halves are in
            if (b.bvalid && bready)
            begin
                b.bvalid <= 1'b0;
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                b_wait   <= pick_delay();
                wr_addr_q.push_back(got_addr);
                wr_data_q.push_back(got_data);
            end
            else if (aw_got && w_got && !b.bvalid && !stall)
            begin
                if (b_wait == 0)
                begin
                    b.bvalid <= 1'b1;
                    b.bresp  <= resp_next;
                end
                else
                    b_wait <= b_wait - 1;
            end
        end
    end

    // error pulses seen on the status output
    always @(negedge clk)
    begin
        if (!rst && status.error)
            error_pulses++;
    end

    // --------------------
    // serial driver
    // --------------------

    task automatic send_byte(input logic [7:0] c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (`HEX_LOADER_CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_line(input string s);
        for (int i = 0; i < s.len(); i++)
            send_byte(s[i]);
    endtask

    // --------------------
    // checks and waits
    // --------------------

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_counters();
        check_value("records_written", 32'(status.records_written), 32'(exp_written));
        check_value("error_count", 32'(status.error_count), 32'(exp_errors));
        check_value("error pulses", 32'(error_pulses), 32'(exp_errors));
    endtask

    // idle for a few cycles in a row so the counters have settled
    task automatic wait_quiet(input string what);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < quiet_cycles && cycles < quiet_limit)
        begin
            @(negedge clk);
            cycles++;
            if (status.busy)
                quiet = 0;
            else
                quiet++;
        end
        if (quiet < quiet_cycles)
        begin
            timeouts++;
            $display("timeout: loader never went idle after %s", what);
        end
    endtask

    task automatic wait_error_count(input int target, input int limit, input string what,
                                    output int cycles);
        @(negedge clk);
        cycles = 1;
        while (32'(status.error_count) != 32'(target) && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (32'(status.error_count) != 32'(target))
        begin
            timeouts++;
            $display("timeout: error counter did not move for %s", what);
        end
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
        if (wr_addr_q.size() <= next_wr)
        begin
            errors++;
            $display("error at %0t: expected write to %h did not happen", $time, addr);
        end
        else
        begin
            check_value("write address", wr_addr_q[next_wr], addr);
            check_value("write data", wr_data_q[next_wr], data);
        end
        next_wr++;
    endtask

    task automatic expect_no_write();
        check_value("write count", 32'(wr_addr_q.size()), 32'(next_wr));
    endtask

    // --------------------
    // stimulus table
    // --------------------

    task automatic add_line(input string text, input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [1:0] resp);
        tbl_text.push_back(text);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_resp.push_back(resp);
    endtask

    task automatic apply_entry(input int i);
        resp_next = tbl_resp[i];
        send_line(tbl_text[i]);
        wait_quiet($sformatf("table line %0d", i));
        if (tbl_write[i])
            expect_write(tbl_addr[i], tbl_data[i]);
        else
            expect_no_write();
        if (tbl_write[i] && tbl_resp[i] == resp_okay)
            exp_written++;
        else
            exp_errors++;
        check_counters();
    endtask

    // line left idle mid-field, the rest up to its line feed is dropped
    task automatic run_timeout_case();
        int cycles;
        resp_next = resp_okay;
        send_line("50 12");
        wait_error_count(exp_errors + 1, `HEX_LOADER_TIMEOUT_CYCLES + 100,
                         "idle line", cycles);
        exp_errors++;
        check_value("timeout not early",
                    32'(cycles >= `HEX_LOADER_TIMEOUT_CYCLES - `HEX_LOADER_CLKS_PER_BIT), 32'd1);
        send_line("34\n");
        wait_quiet("rest of timed out line");
        expect_no_write();
        check_counters();
        send_line("54 99\n");
        wait_quiet("line after timeout");
        expect_write(32'h54, 32'h99);
        exp_written++;
        check_counters();
    endtask

    // one write held by the master, one in the buffer, the third overruns
    task automatic run_overrun_case();
        int cycles;
        resp_next = resp_okay;
        stall     = 1'b1;
        send_line("60 a1\n");
        send_line("64 a2\n");
        send_line("68 a3\n");
        wait_error_count(exp_errors + 1, 1000, "buffer overrun", cycles);
        exp_errors++;
        expect_no_write();
        stall = 1'b0;
        wait_quiet("stalled writes");
        expect_write(32'h60, 32'ha1);
        expect_write(32'h64, 32'ha2);
        exp_written += 2;
        expect_no_write();
        check_counters();
    endtask

    initial
    begin
        rst     <= 1'b1;
        uart_rx <= 1'b1;
        void'($urandom(32'h51ea6c91));

        add_line("1000 DEADBEEF\n", 1'b1, 32'h1000, 32'hdeadbeef, resp_okay);
        add_line("a 5\015\n", 1'b1, 32'h0000000a, 32'h00000005, resp_okay);
        add_line("20   7f\n", 1'b1, 32'h20, 32'h7f, resp_okay);
        add_line("ffffFFFC 12345678\015\n", 1'b1, 32'hfffffffc, 32'h12345678, resp_okay);
        add_line("12g4 55\n", 1'b0, 32'h0, 32'h0, resp_okay);
        add_line("3000\n", 1'b0, 32'h0, 32'h0, resp_okay);
        add_line("3000 \n", 1'b0, 32'h0, 32'h0, resp_okay);
        add_line("123456789 1\n", 1'b0, 32'h0, 32'h0, resp_okay);
        add_line("40 12 34\n", 1'b0, 32'h0, 32'h0, resp_okay);
        add_line("24 0c0ffee\n", 1'b1, 32'h24, 32'h00c0ffee, resp_okay);
        add_line("44 1234abcd\n", 1'b1, 32'h44, 32'h1234abcd, resp_slverr);
        add_line("48 0\n", 1'b1, 32'h48, 32'h0, resp_okay);

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_counters();

        // first pass with a fast slave, second with random ready delays
        for (int pass = 0; pass < 2; pass++)
        begin
            slow = (pass == 1);
            for (int i = 0; i < tbl_text.size(); i++)
                apply_entry(i);
        end

        run_timeout_case();
        run_overrun_case();

        check_value("assertion failures", i_dut.i_props.violations, 32'd0);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/hex_loader_pkg.sv
hdl/uart_receiver.sv
hdl/hex_field_accumulator.sv
hdl/record_assembler.sv
hdl/axil_write_master.sv
hdl/hex_loader_top.sv
sim/hex_loader_properties.sv
sim/tb_hex_loader.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := tb_hex_loader
DUT_TOP    := hex_loader_top
FILELIST   := files.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
